//--- udp_video_pkg.sv
`default_nettype none

package udp_video_pkg;

	typedef logic [7:0]  byte_t;
	typedef logic [10:0] rx_count_t;
	typedef logic [10:0] line_t;
	typedef logic [15:0] pixel_t;
	typedef logic [27:0] fifo_word_t;     // {field, line, pixel}
	typedef logic [31:0] ipv4_t;
	typedef logic [15:0] udp_port_t;
	typedef logic [31:0] csr_data_t;
	typedef logic [3:0]  csr_addr_t;

	localparam logic [15:0] eth_type_ipv4 = 16'h0800;
	localparam byte_t       ip_ver_ihl    = 8'h45;
	localparam byte_t       ip_proto_udp  = 8'd17;

	// Byte offsets from the first preamble byte
	localparam rx_count_t off_eth_type = 11'd20;
	localparam rx_count_t off_ip_ver   = 11'd22;
	localparam rx_count_t off_ip_proto = 11'd31;
	localparam rx_count_t off_ip_dst   = 11'd38;
	localparam rx_count_t off_udp_dst  = 11'd44;
	localparam rx_count_t off_payload  = 11'd50;   // Line low byte, then line high/field

	localparam csr_addr_t reg_dst_ip     = 4'h0;
	localparam csr_addr_t reg_dst_port   = 4'h4;
	localparam csr_addr_t reg_pkt_count  = 4'h8;
	localparam csr_addr_t reg_drop_count = 4'hC;

	typedef enum logic [1:0] {
		pk_idle,
		pk_hi,
		pk_lo
	} pack_state_t;

endpackage

`default_nettype wire

//--- udp_hdr_decode.sv
`timescale 1ns/1ps
`default_nettype none

module udp_hdr_decode #(
	parameter int unsigned max_frame_bytes = 1111
) (
	input  wire                              clk125,
	input  wire                              sys_rst,
	input  wire                              id,
	input  wire udp_video_pkg::byte_t        rxd,
	input  wire                              rx_dv,
	input  wire udp_video_pkg::ipv4_t        dst_ip,
	input  wire udp_video_pkg::udp_port_t    dst_port,
	output logic                             pay_valid,
	output udp_video_pkg::byte_t             pay_byte,
	output udp_video_pkg::line_t             pay_line,
	output logic                             pay_field,
	output logic                             pay_start,
	output logic                             pkt_accept
);

	udp_video_pkg::rx_count_t rx_count;
	logic [15:0]              eth_type;
	udp_video_pkg::byte_t     ip_ver;
	udp_video_pkg::byte_t     ip_proto;
	udp_video_pkg::ipv4_t     ip_dst;
	udp_video_pkg::udp_port_t udp_dst;
	logic                     frame_ok;    // Current frame passed the filter
	logic                     hdr_match;

	// Board id selects base or base+1
	assign hdr_match = (eth_type == udp_video_pkg::eth_type_ipv4) &&
		(ip_ver == udp_video_pkg::ip_ver_ihl) &&
		(ip_proto == udp_video_pkg::ip_proto_udp) &&
		(ip_dst == udp_video_pkg::ipv4_t'(dst_ip + 32'(id))) &&
		(udp_dst == dst_port);

	assign pkt_accept = pay_start;

	always_ff @(posedge clk125) begin
		if (sys_rst) begin
			rx_count  <= '0;
			frame_ok  <= 1'b0;
			pay_start <= 1'b0;
			pay_valid <= 1'b0;
		end else begin
			pay_start <= 1'b0;
			pay_valid <= 1'b0;
			if (rx_dv) begin
				if (rx_count != '1) begin
					rx_count <= rx_count + 11'd1;   // Saturate on runt-free giants
				end
				if (rx_count == udp_video_pkg::off_payload && hdr_match) begin
					frame_ok  <= 1'b1;
					pay_start <= 1'b1;
				end
				if (frame_ok && rx_count >= udp_video_pkg::off_payload + 11'd2 &&
						rx_count < max_frame_bytes) begin
					pay_valid <= 1'b1;               // Pixel bytes only
				end
			end else begin
				rx_count <= '0;
				frame_ok <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk125) begin
		pay_byte <= rxd;
		if (rx_dv) begin
			case (rx_count)
				udp_video_pkg::off_eth_type:          eth_type[15:8]  <= rxd;
				udp_video_pkg::off_eth_type + 11'd1:  eth_type[7:0]   <= rxd;
				udp_video_pkg::off_ip_ver:            ip_ver          <= rxd;
				udp_video_pkg::off_ip_proto:          ip_proto        <= rxd;
				udp_video_pkg::off_ip_dst:            ip_dst[31:24]   <= rxd;
				udp_video_pkg::off_ip_dst + 11'd1:    ip_dst[23:16]   <= rxd;
				udp_video_pkg::off_ip_dst + 11'd2:    ip_dst[15:8]    <= rxd;
				udp_video_pkg::off_ip_dst + 11'd3:    ip_dst[7:0]     <= rxd;
				udp_video_pkg::off_udp_dst:           udp_dst[15:8]   <= rxd;
				udp_video_pkg::off_udp_dst + 11'd1:   udp_dst[7:0]    <= rxd;
				udp_video_pkg::off_payload: begin
					if (hdr_match) begin
						pay_line[7:0] <= rxd;
					end
				end
				udp_video_pkg::off_payload + 11'd1: begin
					if (frame_ok) begin
						pay_line[10:8] <= rxd[2:0];   // Line bits 10:8
						pay_field      <= rxd[4];     // Field in the upper nibble
					end
				end
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- yuv_word_pack.sv
`timescale 1ns/1ps
`default_nettype none

module yuv_word_pack (
	input  wire                          clk125,
	input  wire                          sys_rst,
	input  wire                          pay_valid,
	input  wire udp_video_pkg::byte_t    pay_byte,
	input  wire udp_video_pkg::line_t    pay_line,
	input  wire                          pay_field,
	input  wire                          pay_start,
	output logic                         wr_valid,
	output udp_video_pkg::fifo_word_t    wr_word
);

	udp_video_pkg::pack_state_t state;
	udp_video_pkg::byte_t       hi_byte;
	udp_video_pkg::pixel_t      pixel;
	logic                       armed;     // Waiting for the first pixel byte

	assign pixel = {hi_byte, pay_byte};

	always_ff @(posedge clk125) begin
		if (sys_rst) begin
			state    <= udp_video_pkg::pk_idle;
			armed    <= 1'b0;
			wr_valid <= 1'b0;
		end else begin
			wr_valid <= 1'b0;
			if (pay_start) begin
				state <= udp_video_pkg::pk_hi;
				armed <= 1'b1;
			end else begin
				case (state)
					udp_video_pkg::pk_idle: ;
					udp_video_pkg::pk_hi: begin
						if (pay_valid) begin
							state <= udp_video_pkg::pk_lo;
							armed <= 1'b0;
						end else if (!armed) begin
							state <= udp_video_pkg::pk_idle;   // Frame ended on a pair boundary
						end
					end
					udp_video_pkg::pk_lo: begin
						if (pay_valid) begin
							state    <= udp_video_pkg::pk_hi;
							wr_valid <= 1'b1;
						end else begin
							state <= udp_video_pkg::pk_idle;   // Odd trailing byte is lost
						end
					end
					default: state <= udp_video_pkg::pk_idle;
				endcase
			end
		end
	end

	always_ff @(posedge clk125) begin
		if (state == udp_video_pkg::pk_hi && pay_valid) begin
			hi_byte <= pay_byte;
		end
		if (state == udp_video_pkg::pk_lo && pay_valid) begin
			wr_word <= {pay_field, pay_line, pixel};
		end
	end

endmodule

`default_nettype wire

//--- line_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module line_fifo #(
	parameter int unsigned fifo_depth = 64
) (
	input  wire                              clk125,
	input  wire                              sys_rst,
	input  wire                              wr_valid,
	input  wire udp_video_pkg::fifo_word_t   wr_word,
	input  wire                              pix_ready,
	output logic                             pix_valid,
	output udp_video_pkg::fifo_word_t        pix_data,
	output logic                             drop
);

	localparam int unsigned aw = $clog2(fifo_depth);

	udp_video_pkg::fifo_word_t mem [fifo_depth];
	logic [aw-1:0]             wr_ptr;
	logic [aw-1:0]             rd_ptr;
	logic [aw:0]               count;
	logic                      full;
	logic                      rd_en;
	logic                      wr_en;

	assign full      = (count == (aw + 1)'(fifo_depth));
	assign pix_valid = (count != '0);
	assign pix_data  = mem[rd_ptr];
	assign rd_en     = pix_valid & pix_ready;
	assign wr_en     = wr_valid & (~full | rd_en);   // Pop frees a slot in the same cycle

	always_ff @(posedge clk125) begin
		if (sys_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			drop   <= 1'b0;
		end else begin
			if (wr_en) begin
				wr_ptr <= wr_ptr + 1'b1;   // Wraps at fifo_depth
			end
			if (rd_en) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			count <= count + (aw + 1)'(wr_en) - (aw + 1)'(rd_en);
			drop  <= wr_valid & ~wr_en;
		end
	end

	always_ff @(posedge clk125) begin
		if (wr_en) begin
			mem[wr_ptr] <= wr_word;
		end
	end

endmodule

`default_nettype wire

//--- rx_csr_axil.sv
`timescale 1ns/1ps
`default_nettype none

module rx_csr_axil #(
	parameter udp_video_pkg::ipv4_t     dst_ip_reset   = {8'd192, 8'd168, 8'd0, 8'd1},
	parameter udp_video_pkg::udp_port_t dst_port_reset = 16'd12345
) (
	input  wire                              clk125,
	input  wire                              sys_rst,
	input  wire                              awvalid,
	input  wire udp_video_pkg::csr_addr_t    awaddr,
	input  wire                              wvalid,
	input  wire udp_video_pkg::csr_data_t    wdata,
	input  wire                              bready,
	input  wire                              arvalid,
	input  wire udp_video_pkg::csr_addr_t    araddr,
	input  wire                              rready,
	input  wire                              pkt_accept,
	input  wire                              drop,
	output logic                             awready,
	output logic                             wready,
	output logic                             bvalid,
	output logic [1:0]                       bresp,
	output logic                             arready,
	output logic                             rvalid,
	output udp_video_pkg::csr_data_t         rdata,
	output udp_video_pkg::ipv4_t             dst_ip,
	output udp_video_pkg::udp_port_t         dst_port
);

	udp_video_pkg::csr_data_t pkt_count;
	udp_video_pkg::csr_data_t drop_count;
	logic                     wr_fire;
	logic                     rd_fire;

	assign wr_fire = awvalid & wvalid & ~bvalid;   // Both channels together
	assign awready = wr_fire;
	assign wready  = wr_fire;
	assign bresp   = 2'b00;                        // OKAY
	assign arready = ~rvalid;
	assign rd_fire = arvalid & arready;

	always_ff @(posedge clk125) begin
		if (sys_rst) begin
			bvalid     <= 1'b0;
			rvalid     <= 1'b0;
			dst_ip     <= dst_ip_reset;
			dst_port   <= dst_port_reset;
			pkt_count  <= '0;
			drop_count <= '0;
		end else begin
			if (wr_fire) begin
				bvalid <= 1'b1;
				case (awaddr)
					udp_video_pkg::reg_dst_ip:   dst_ip   <= wdata;
					udp_video_pkg::reg_dst_port: dst_port <= wdata[15:0];
					default: ;                 // Counters are read only
				endcase
			end else if (bready) begin
				bvalid <= 1'b0;
			end
			if (rd_fire) begin
				rvalid <= 1'b1;
			end else if (rready) begin
				rvalid <= 1'b0;
			end
			pkt_count  <= pkt_count + 32'(pkt_accept);
			drop_count <= drop_count + 32'(drop);
		end
	end

	always_ff @(posedge clk125) begin
		if (rd_fire) begin
			case (araddr)
				udp_video_pkg::reg_dst_ip:     rdata <= dst_ip;
				udp_video_pkg::reg_dst_port:   rdata <= {16'd0, dst_port};
				udp_video_pkg::reg_pkt_count:  rdata <= pkt_count;
				udp_video_pkg::reg_drop_count: rdata <= drop_count;
				default:                       rdata <= '0;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- gmii_udp_video_rx.sv
`timescale 1ns/1ps
`default_nettype none

module gmii_udp_video_rx #(
	parameter udp_video_pkg::ipv4_t     dst_ip_reset    = {8'd192, 8'd168, 8'd0, 8'd1},
	parameter udp_video_pkg::udp_port_t dst_port_reset  = 16'd12345,
	parameter int unsigned              max_frame_bytes = 1111,
	parameter int unsigned              fifo_depth      = 64
) (
	input  wire                              clk125,
	input  wire                              sys_rst,
	input  wire                              id,
	input  wire udp_video_pkg::byte_t        rxd,
	input  wire                              rx_dv,
	output logic                             pix_valid,
	output udp_video_pkg::fifo_word_t        pix_data,
	input  wire                              pix_ready,
	input  wire                              awvalid,
	output logic                             awready,
	input  wire udp_video_pkg::csr_addr_t    awaddr,
	input  wire                              wvalid,
	output logic                             wready,
	input  wire udp_video_pkg::csr_data_t    wdata,
	output logic                             bvalid,
	input  wire                              bready,
	output logic [1:0]                       bresp,
	input  wire                              arvalid,
	output logic                             arready,
	input  wire udp_video_pkg::csr_addr_t    araddr,
	output logic                             rvalid,
	input  wire                              rready,
	output udp_video_pkg::csr_data_t         rdata
);

	udp_video_pkg::ipv4_t      dst_ip;
	udp_video_pkg::udp_port_t  dst_port;
	udp_video_pkg::byte_t      pay_byte;
	udp_video_pkg::line_t      pay_line;
	udp_video_pkg::fifo_word_t wr_word;
	logic                      pay_valid;
	logic                      pay_field;
	logic                      pay_start;
	logic                      pkt_accept;
	logic                      wr_valid;
	logic                      drop;

	udp_hdr_decode #(
		.max_frame_bytes(max_frame_bytes)
	) u_decode (
		.clk125    (clk125),
		.sys_rst   (sys_rst),
		.id        (id),
		.rxd       (rxd),
		.rx_dv     (rx_dv),
		.dst_ip    (dst_ip),
		.dst_port  (dst_port),
		.pay_valid (pay_valid),
		.pay_byte  (pay_byte),
		.pay_line  (pay_line),
		.pay_field (pay_field),
		.pay_start (pay_start),
		.pkt_accept(pkt_accept)
	);

	yuv_word_pack u_pack (
		.clk125   (clk125),
		.sys_rst  (sys_rst),
		.pay_valid(pay_valid),
		.pay_byte (pay_byte),
		.pay_line (pay_line),
		.pay_field(pay_field),
		.pay_start(pay_start),
		.wr_valid (wr_valid),
		.wr_word  (wr_word)
	);

	line_fifo #(
		.fifo_depth(fifo_depth)
	) u_fifo (
		.clk125   (clk125),
		.sys_rst  (sys_rst),
		.wr_valid (wr_valid),
		.wr_word  (wr_word),
		.pix_ready(pix_ready),
		.pix_valid(pix_valid),
		.pix_data (pix_data),
		.drop     (drop)
	);

	rx_csr_axil #(
		.dst_ip_reset  (dst_ip_reset),
		.dst_port_reset(dst_port_reset)
	) u_csr (
		.clk125    (clk125),
		.sys_rst   (sys_rst),
		.awvalid   (awvalid),
		.awaddr    (awaddr),
		.wvalid    (wvalid),
		.wdata     (wdata),
		.bready    (bready),
		.arvalid   (arvalid),
		.araddr    (araddr),
		.rready    (rready),
		.pkt_accept(pkt_accept),
		.drop      (drop),
		.awready   (awready),
		.wready    (wready),
		.bvalid    (bvalid),
		.bresp     (bresp),
		.arready   (arready),
		.rvalid    (rvalid),
		.rdata     (rdata),
		.dst_ip    (dst_ip),
		.dst_port  (dst_port)
	);

endmodule

`default_nettype wire

//--- gmii_udp_video_rx_assert.sv
`timescale 1ns/1ps
`default_nettype none

module gmii_udp_video_rx_assert (
	input wire                            clk125,
	input wire                            sys_rst,
	input wire                            pix_valid,
	input wire                            pix_ready,
	input wire udp_video_pkg::fifo_word_t pix_data,
	input wire                            bvalid,
	input wire                            bready,
	input wire                            rvalid,
	input wire                            rready
);

	// Stalled word must not move
	pix_hold: assert property (@(posedge clk125) disable iff (sys_rst)
		pix_valid && !pix_ready |=> pix_valid && $stable(pix_data))
		else $error("pix_data changed or pix_valid dropped while stalled");

	b_hold: assert property (@(posedge clk125) disable iff (sys_rst)
		bvalid && !bready |=> bvalid)
		else $error("bvalid dropped before bready");

	r_hold: assert property (@(posedge clk125) disable iff (sys_rst)
		rvalid && !rready |=> rvalid)
		else $error("rvalid dropped before rready");

	reset_clear: assert property (@(posedge clk125) sys_rst |=> !pix_valid)
		else $error("pix_valid high right after reset");

endmodule

bind gmii_udp_video_rx gmii_udp_video_rx_assert u_assert (
	.clk125   (clk125),
	.sys_rst  (sys_rst),
	.pix_valid(pix_valid),
	.pix_ready(pix_ready),
	.pix_data (pix_data),
	.bvalid   (bvalid),
	.bready   (bready),
	.rvalid   (rvalid),
	.rready   (rready)
);

`default_nettype wire

//--- tb_gmii_udp_video_rx.sv
`timescale 1ns/1ps
`default_nettype none

module tb_gmii_udp_video_rx;

	localparam int unsigned          max_frame_bytes = 1111;
	localparam int unsigned          fifo_depth      = 64;
	localparam int unsigned          timeout_cycles  = 20000;
	localparam udp_video_pkg::ipv4_t base_ip         = {8'd192, 8'd168, 8'd0, 8'd1};
	localparam udp_video_pkg::udp_port_t base_port   = 16'd12345;

	logic                      clk125;
	logic                      sys_rst;
	logic                      id;
	udp_video_pkg::byte_t      rxd;
	logic                      rx_dv;
	logic                      pix_valid;
	udp_video_pkg::fifo_word_t pix_data;
	logic                      pix_ready;
	logic                      awvalid;
	logic                      awready;
	udp_video_pkg::csr_addr_t  awaddr;
	logic                      wvalid;
	logic                      wready;
	udp_video_pkg::csr_data_t  wdata;
	logic                      bvalid;
	logic                      bready;
	logic [1:0]                bresp;
	logic                      arvalid;
	logic                      arready;
	udp_video_pkg::csr_addr_t  araddr;
	logic                      rvalid;
	logic                      rready;
	udp_video_pkg::csr_data_t  rdata;

	udp_video_pkg::fifo_word_t exp_q[$];    // Words still to come out of the stream
	int                        mismatches   = 0;
	int                        other_errors = 0;
	int                        exp_pkts     = 0;
	int                        exp_drops    = 0;
	int                        cycle_count  = 0;
	int                        ready_mode   = 0;    // 0 high, 1 low, 2 random
	logic [31:0]               pix_seed     = 32'd8763;
	logic [31:0]               rdy_seed     = 32'd8763;
	string                     test_name    = "reset";
	udp_video_pkg::ipv4_t      cur_ip       = base_ip;
	udp_video_pkg::udp_port_t  cur_port     = base_port;

	gmii_udp_video_rx #(
		.dst_ip_reset   (base_ip),
		.dst_port_reset (base_port),
		.max_frame_bytes(max_frame_bytes),
		.fifo_depth     (fifo_depth)
	) u_dut (
		.clk125(clk125), .sys_rst(sys_rst), .id(id), .rxd(rxd), .rx_dv(rx_dv),
		.pix_valid(pix_valid), .pix_data(pix_data), .pix_ready(pix_ready),
		.awvalid(awvalid), .awready(awready), .awaddr(awaddr),
		.wvalid(wvalid), .wready(wready), .wdata(wdata),
		.bvalid(bvalid), .bready(bready), .bresp(bresp),
		.arvalid(arvalid), .arready(arready), .araddr(araddr),
		.rvalid(rvalid), .rready(rready), .rdata(rdata)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic next_cycle;
		@(posedge clk125);
		#2;
	endtask

	task automatic check_equal(input string what, input logic [31:0] exp,
			input logic [31:0] got);
		assert (exp === got) else begin
			mismatches++;
			$display("mismatch %s %s: expected %h actual %h", test_name, what, exp, got);
		end
	endtask

	task automatic axi_write(input udp_video_pkg::csr_addr_t addr,
			input udp_video_pkg::csr_data_t data);
		awaddr  = addr;
		wdata   = data;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		bready  = 1'b0;
		@(negedge clk125);
		while (!(awready && wready)) begin
			next_cycle();
			@(negedge clk125);
		end
		next_cycle();                 // Handshake edge has passed
		awvalid = 1'b0;
		wvalid  = 1'b0;
		@(negedge clk125);
		while (!bvalid) begin
			next_cycle();
			@(negedge clk125);
		end
		next_cycle();                 // Response stalls one cycle
		bready = 1'b1;
		@(negedge clk125);
		check_equal("bresp", 32'd0, 32'(bresp));
		next_cycle();
		bready = 1'b0;
	endtask

	task automatic read_check(input string what, input udp_video_pkg::csr_addr_t addr,
			input udp_video_pkg::csr_data_t exp);
		udp_video_pkg::csr_data_t got;
		araddr  = addr;
		arvalid = 1'b1;
		rready  = 1'b0;
		@(negedge clk125);
		while (!arready) begin
			next_cycle();
			@(negedge clk125);
		end
		next_cycle();
		arvalid = 1'b0;
		@(negedge clk125);
		while (!rvalid) begin
			next_cycle();
			@(negedge clk125);
		end
		next_cycle();                 // Read data stalls one cycle
		rready = 1'b1;
		@(negedge clk125);
		got = rdata;
		next_cycle();
		rready = 1'b0;
		check_equal(what, exp, got);
	endtask

	// Builds one frame, queues the words it should produce and drives it on GMII
	task automatic send_frame(input logic [15:0] etype, input udp_video_pkg::byte_t proto,
			input udp_video_pkg::ipv4_t ip, input udp_video_pkg::udp_port_t port,
			input udp_video_pkg::line_t line, input logic field, input int pix_bytes,
			input bit accept, input int keep_words);
		udp_video_pkg::byte_t frame[$];
		udp_video_pkg::byte_t pix[$];
		logic [15:0]          udp_len;
		logic [15:0]          ip_len;
		int                   words_in;
		int                   k;
		udp_len  = 16'(10 + pix_bytes);
		ip_len   = 16'(30 + pix_bytes);
		words_in = 0;
		repeat (7) frame.push_back(8'h55);
		frame.push_back(8'hD5);
		for (k = 0; k < 12; k++) frame.push_back(8'(k + 2));   // Both MAC addresses
		frame.push_back(etype[15:8]);
		frame.push_back(etype[7:0]);
		frame.push_back(8'h45);
		frame.push_back(8'h00);
		frame.push_back(ip_len[15:8]);
		frame.push_back(ip_len[7:0]);
		repeat (2) frame.push_back(8'h00);
		frame.push_back(8'h40);                                 // DF flag
		frame.push_back(8'h00);
		frame.push_back(8'h40);                                 // TTL
		frame.push_back(proto);
		repeat (2) frame.push_back(8'h00);
		for (k = 3; k >= 0; k--) frame.push_back(base_ip[8*k +: 8] + 8'd9);
		for (k = 3; k >= 0; k--) frame.push_back(ip[8*k +: 8]);
		frame.push_back(8'h1F);
		frame.push_back(8'h90);
		frame.push_back(port[15:8]);
		frame.push_back(port[7:0]);
		frame.push_back(udp_len[15:8]);
		frame.push_back(udp_len[7:0]);
		repeat (2) frame.push_back(8'h00);
		frame.push_back(line[7:0]);
		frame.push_back({3'b000, field, 1'b0, line[10:8]});     // Field at bit 4
		for (k = 0; k < pix_bytes; k++) begin
			pix_seed = lcg_next(pix_seed);
			pix.push_back(pix_seed[23:16]);
			frame.push_back(pix_seed[23:16]);
		end
		if (accept) begin
			exp_pkts++;
			// Low byte of pixel k sits at offset 53 + 2k
			for (k = 0; 2 * k + 1 < pix_bytes && 53 + 2 * k < max_frame_bytes; k++) begin
				if (words_in < keep_words) begin
					exp_q.push_back({field, line, pix[2*k], pix[2*k+1]});
				end else begin
					exp_drops++;
				end
				words_in++;
			end
		end
		foreach (frame[i]) begin
			next_cycle();
			rx_dv = 1'b1;
			rxd   = frame[i];
		end
		next_cycle();
		rx_dv = 1'b0;
		rxd   = 8'h00;
		repeat (12) next_cycle();                               // Inter-frame gap
	endtask

	task automatic wait_drain;
		while (exp_q.size() != 0) next_cycle();
		repeat (8) next_cycle();   // Room for stray words to show up
	endtask

	task automatic test_basic;
		test_name = "basic";
		send_frame(udp_video_pkg::eth_type_ipv4, 8'd17, cur_ip, cur_port, 11'd300, 1'b1, 64, 1,
			fifo_depth);
		wait_drain();
		read_check("pkt_count", udp_video_pkg::reg_pkt_count, 32'(exp_pkts));
	endtask

	task automatic test_filter;
		test_name = "filter";
		send_frame(16'h86DD, 8'd17, cur_ip, cur_port, 11'd5, 1'b0, 16, 0, fifo_depth);
		send_frame(udp_video_pkg::eth_type_ipv4, 8'd6, cur_ip, cur_port, 11'd5, 1'b0, 16, 0,
			fifo_depth);
		send_frame(udp_video_pkg::eth_type_ipv4, 8'd17, cur_ip, cur_port + 16'd1, 11'd5, 1'b0,
			16, 0, fifo_depth);
		send_frame(udp_video_pkg::eth_type_ipv4, 8'd17, cur_ip + 32'd1, cur_port, 11'd5, 1'b0,
			16, 0, fifo_depth);
		read_check("pkt_count after rejects", udp_video_pkg::reg_pkt_count, 32'(exp_pkts));
		id = 1'b1;
		send_frame(udp_video_pkg::eth_type_ipv4, 8'd17, cur_ip, cur_port, 11'd6, 1'b0, 16, 0,
			fifo_depth);
		send_frame(udp_video_pkg::eth_type_ipv4, 8'd17, cur_ip + 32'd1, cur_port, 11'd2047,
			1'b1, 16, 1, fifo_depth);
		wait_drain();
		id = 1'b0;
		read_check("pkt_count", udp_video_pkg::reg_pkt_count, 32'(exp_pkts));
	endtask

	task automatic test_config;
		udp_video_pkg::ipv4_t old_ip;
		test_name = "config";
		old_ip    = cur_ip;
		cur_ip    = {8'd10, 8'd1, 8'd2, 8'd50};
		cur_port  = 16'd5004;
		axi_write(udp_video_pkg::reg_dst_ip, cur_ip);
		axi_write(udp_video_pkg::reg_dst_port, 32'(cur_port));
		read_check("dst_ip", udp_video_pkg::reg_dst_ip, cur_ip);
		read_check("dst_port", udp_video_pkg::reg_dst_port, 32'(cur_port));
		send_frame(udp_video_pkg::eth_type_ipv4, 8'd17, old_ip, cur_port, 11'd7, 1'b0, 32, 0,
			fifo_depth);
		send_frame(udp_video_pkg::eth_type_ipv4, 8'd17, cur_ip, cur_port, 11'd8, 1'b1, 32, 1,
			fifo_depth);
		wait_drain();
		read_check("pkt_count", udp_video_pkg::reg_pkt_count, 32'(exp_pkts));
	endtask

	task automatic test_backpressure;
		test_name  = "overflow";
		ready_mode = 1;
		send_frame(udp_video_pkg::eth_type_ipv4, 8'd17, cur_ip, cur_port, 11'd100, 1'b0, 200,
			1, fifo_depth);
		read_check("drop_count", udp_video_pkg::reg_drop_count, 32'(exp_drops));
		ready_mode = 0;
		wait_drain();
		test_name  = "random_ready";
		ready_mode = 2;
		send_frame(udp_video_pkg::eth_type_ipv4, 8'd17, cur_ip, cur_port, 11'd101, 1'b1, 80,
			1, fifo_depth);
		wait_drain();
		ready_mode = 0;
		read_check("drop_count", udp_video_pkg::reg_drop_count, 32'(exp_drops));
	endtask

	task automatic test_length;
		test_name = "odd_length";
		send_frame(udp_video_pkg::eth_type_ipv4, 8'd17, cur_ip, cur_port, 11'd400, 1'b0, 21,
			1, fifo_depth);
		wait_drain();
		test_name = "max_length";
		send_frame(udp_video_pkg::eth_type_ipv4, 8'd17, cur_ip, cur_port, 11'd401, 1'b1, 1200,
			1, 100000);
		wait_drain();
		read_check("pkt_count", udp_video_pkg::reg_pkt_count, 32'(exp_pkts));
		read_check("drop_count", udp_video_pkg::reg_drop_count, 32'(exp_drops));
	endtask

	initial begin
		clk125 = 1'b0;
		forever #10 clk125 = ~clk125;
	end

	// Mode is taken at the falling edge so a change never races the drive
	initial begin
		int mode_now;
		pix_ready = 1'b0;
		forever begin
			@(negedge clk125);
			mode_now = ready_mode;
			@(posedge clk125);
			#2;
			rdy_seed = lcg_next(rdy_seed);
			case (mode_now)
				1:       pix_ready = 1'b0;
				2:       pix_ready = rdy_seed[20];
				default: pix_ready = 1'b1;
			endcase
		end
	end

	// A transfer seen here completes at the next rising edge
	always @(negedge clk125) begin
		if (!sys_rst && pix_valid && pix_ready) begin
			assert (exp_q.size() != 0) else begin
				other_errors++;
				$display("%s: pixel word %h came out with none expected", test_name, pix_data);
			end
			if (exp_q.size() != 0) begin
				check_equal("pixel word", 32'(exp_q.pop_front()), 32'(pix_data));
			end
		end
	end

	initial begin
		while (cycle_count < timeout_cycles) begin
			@(posedge clk125);
			cycle_count++;
		end
		$display("timeout: the run did not finish within %0d cycles", timeout_cycles);
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial begin
		sys_rst = 1'b1;
		id      = 1'b0;
		rxd     = 8'h00;
		rx_dv   = 1'b0;
		awvalid = 1'b0;
		awaddr  = '0;
		wvalid  = 1'b0;
		wdata   = '0;
		bready  = 1'b0;
		arvalid = 1'b0;
		araddr  = '0;
		rready  = 1'b0;
		repeat (10) @(posedge clk125);
		#2;
		sys_rst = 1'b0;
		repeat (4) next_cycle();
		test_basic();
		test_filter();
		test_config();
		test_backpressure();
		test_length();
		$display("summary: %0d mismatches, %0d other errors", mismatches, other_errors);
		if (mismatches + other_errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- gmii_udp_video_rx.f
udp_video_pkg.sv
udp_hdr_decode.sv
yuv_word_pack.sv
line_fifo.sv
rx_csr_axil.sv
gmii_udp_video_rx.sv
gmii_udp_video_rx_assert.sv
tb_gmii_udp_video_rx.sv

//--- Bender.yml
package:
  name: gmii_udp_video_rx

sources:
  - files:
      - udp_video_pkg.sv
      - udp_hdr_decode.sv
      - yuv_word_pack.sv
      - line_fifo.sv
      - rx_csr_axil.sv
      - gmii_udp_video_rx.sv
  - target: test
    files:
      - gmii_udp_video_rx_assert.sv
      - tb_gmii_udp_video_rx.sv
